// ==== source/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

  // widths with a meaning of their own
  typedef logic [31:0] word_t;      // data or address word
  typedef logic [4:0]  reg_addr_t;  // gpr index
  typedef logic [11:0] csr_addr_t;
  typedef logic [4:0]  opcode_t;    // instr[6:2]
  typedef logic [2:0]  funct_t;     // funct3

  // major opcodes, instr[6:2]
  localparam opcode_t OP_LUI    = 5'b01101;
  localparam opcode_t OP_AUIPC  = 5'b00101;
  localparam opcode_t OP_JAL    = 5'b11011;
  localparam opcode_t OP_JALR   = 5'b11001;
  localparam opcode_t OP_BRANCH = 5'b11000;
  localparam opcode_t OP_LOAD   = 5'b00000;
  localparam opcode_t OP_STORE  = 5'b01000;
  localparam opcode_t OP_CALRI  = 5'b00100;  // reg-imm alu
  localparam opcode_t OP_CALRR  = 5'b01100;  // reg-reg alu
  localparam opcode_t OP_SYS    = 5'b11100;  // ecall, mret, csr ops

  // branch conditions
  localparam funct_t BR_BEQ  = 3'b000;
  localparam funct_t BR_BNE  = 3'b001;
  localparam funct_t BR_BLT  = 3'b100;
  localparam funct_t BR_BGE  = 3'b101;
  localparam funct_t BR_BLTU = 3'b110;
  localparam funct_t BR_BGEU = 3'b111;

  // alu ops, funcs picks sub / sra
  localparam funct_t ALU_ADD  = 3'b000;
  localparam funct_t ALU_SLL  = 3'b001;
  localparam funct_t ALU_SLT  = 3'b010;
  localparam funct_t ALU_SLTU = 3'b011;
  localparam funct_t ALU_XOR  = 3'b100;
  localparam funct_t ALU_SR   = 3'b101;
  localparam funct_t ALU_OR   = 3'b110;
  localparam funct_t ALU_AND  = 3'b111;

  // load / store widths
  localparam funct_t MEM_B  = 3'b000;
  localparam funct_t MEM_H  = 3'b001;
  localparam funct_t MEM_W  = 3'b010;
  localparam funct_t MEM_BU = 3'b100;
  localparam funct_t MEM_HU = 3'b101;

  localparam csr_addr_t CSR_MEPC   = 12'h341;
  localparam csr_addr_t CSR_MCAUSE = 12'h342;

  localparam word_t CAUSE_ECALL_M = 32'd11;  // environment call from m-mode

  // what the execute controller is still waiting for
  typedef enum logic [1:0] {
    EX_IDLE,
    EX_WAIT_NPC,
    EX_WAIT_MEM,
    EX_WAIT_BOTH
  } exu_state_t;

endpackage

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire exu_pkg::word_t  a,
  input  wire exu_pkg::word_t  b,
  input  wire exu_pkg::funct_t funct,
  input  wire                  funcs,
  output exu_pkg::word_t       val
);

  logic [4:0] shamt;
  exu_pkg::word_t sum;
  exu_pkg::word_t srl_val;
  exu_pkg::word_t sra_val;
  logic lt_s;
  logic lt_u;

  assign shamt = b[4:0];

  // funcs turns add into sub, also used by beq/bne
  assign sum = funcs ? a - b : a + b;

  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  // kept in its own assign so the shift stays signed
  assign sra_val = $signed(a) >>> shamt;
  assign srl_val = a >> shamt;

  always_comb begin
    case (funct)
      exu_pkg::ALU_ADD: begin
        val = sum;
      end
      exu_pkg::ALU_SLL: begin
        val = a << shamt;
      end
      exu_pkg::ALU_SLT: begin
        val = {31'b0, lt_s};  // bit 0 feeds blt/bge
      end
      exu_pkg::ALU_SLTU: begin
        val = {31'b0, lt_u};
      end
      exu_pkg::ALU_XOR: begin
        val = a ^ b;
      end
      exu_pkg::ALU_SR: begin
        val = funcs ? sra_val : srl_val;
      end
      exu_pkg::ALU_OR: begin
        val = a | b;
      end
      exu_pkg::ALU_AND: begin
        val = a & b;
      end
      default: begin
        val = sum;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
  input  wire exu_pkg::word_t   pc,
  input  wire exu_pkg::word_t   src1,
  input  wire exu_pkg::word_t   imm,
  input  wire exu_pkg::word_t   csr,
  input  wire exu_pkg::opcode_t opcode,
  input  wire exu_pkg::funct_t  funct,
  input  wire exu_pkg::word_t   alu_val,
  output exu_pkg::word_t        npc
);

  logic alu_zero;
  logic br_taken;
  logic csr_jump;
  exu_pkg::word_t base;
  exu_pkg::word_t inc;
  exu_pkg::word_t sum;

  assign alu_zero = (alu_val == '0);

  // only meaningful for OP_BRANCH
  always_comb begin
    case (funct)
      exu_pkg::BR_BEQ:                  br_taken = alu_zero;
      exu_pkg::BR_BNE:                  br_taken = ~alu_zero;
      exu_pkg::BR_BLT, exu_pkg::BR_BLTU: br_taken = alu_val[0];
      exu_pkg::BR_BGE, exu_pkg::BR_BGEU: br_taken = ~alu_val[0];
      default:                          br_taken = 1'b0;
    endcase
  end

  // ecall and mret, target comes in on csr (mtvec / mepc)
  assign csr_jump = (opcode == exu_pkg::OP_SYS) && (funct == '0);

  always_comb begin
    if (opcode == exu_pkg::OP_JALR) begin
      base = src1;
    end else if (csr_jump) begin
      base = csr;
    end else begin
      base = pc;
    end
  end

  always_comb begin
    case (opcode)
      exu_pkg::OP_JAL, exu_pkg::OP_JALR: begin
        inc = imm;
      end
      exu_pkg::OP_BRANCH: begin
        inc = br_taken ? imm : 32'd4;
      end
      exu_pkg::OP_SYS: begin
        inc = csr_jump ? 32'd0 : 32'd4;  // csr ops just fall through
      end
      default: begin
        inc = 32'd4;
      end
    endcase
  end

  assign sum = base + inc;
  assign npc = {sum[31:1], 1'b0};  // jalr rule, harmless elsewhere

endmodule

`default_nettype wire

// ==== source/exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu (
  input  wire                     clk,
  input  wire                     rstn,
  // decoded instruction
  input  wire                     id_valid,
  output logic                    id_ready,
  input  wire exu_pkg::word_t     pc,
  input  wire exu_pkg::opcode_t   opcode,
  input  wire exu_pkg::funct_t    funct,
  input  wire exu_pkg::reg_addr_t rd,
  input  wire exu_pkg::word_t     src1,
  input  wire exu_pkg::word_t     src2,
  input  wire exu_pkg::word_t     imm,
  input  wire exu_pkg::word_t     csr,
  input  wire exu_pkg::word_t     alu_a,
  input  wire exu_pkg::word_t     alu_b,
  input  wire exu_pkg::funct_t    alu_funct,
  input  wire                     alu_funcs,
  // next pc to fetch
  output logic                    npc_valid,
  input  wire                     npc_ready,
  output exu_pkg::word_t          npc,
  // register file and csr write pulses
  output logic                    gpr_wen,
  output exu_pkg::reg_addr_t      gpr_waddr,
  output exu_pkg::word_t          gpr_wdata,
  output logic                    csr_wen1,
  output exu_pkg::csr_addr_t      csr_waddr1,
  output exu_pkg::word_t          csr_wdata1,
  output logic                    csr_wen2,
  output exu_pkg::csr_addr_t      csr_waddr2,
  output exu_pkg::word_t          csr_wdata2,
  // lsu channels
  output logic                    rreq_valid,
  input  wire                     rreq_ready,
  output exu_pkg::word_t          mem_raddr,
  output exu_pkg::funct_t         mem_rfunc,
  input  wire                     rres_valid,
  output logic                    rres_ready,
  input  wire exu_pkg::word_t     mem_rdata,
  output logic                    wreq_valid,
  input  wire                     wreq_ready,
  output exu_pkg::word_t          mem_waddr,
  output exu_pkg::funct_t         mem_wfunc,
  output exu_pkg::word_t          mem_wdata,
  input  wire                     wres_valid,
  output logic                    wres_ready
);

  exu_pkg::word_t alu_val;
  exu_pkg::word_t id_npc;
  exu_pkg::word_t id_gpr_wdata;
  exu_pkg::exu_state_t state;
  exu_pkg::exu_state_t state_nxt;
  logic id_hs;
  logic npc_hs;
  logic mem_done;
  logic is_load;
  logic is_store;
  logic is_sys;
  logic csr_op;
  logic ecall;
  logic id_gpr_wen;

  alu u_alu (
    .a     (alu_a),
    .b     (alu_b),
    .funct (alu_funct),
    .funcs (alu_funcs),
    .val   (alu_val)
  );

  branch_unit u_branch (
    .pc      (pc),
    .src1    (src1),
    .imm     (imm),
    .csr     (csr),
    .opcode  (opcode),
    .funct   (funct),
    .alu_val (alu_val),
    .npc     (id_npc)
  );

  assign id_hs    = id_valid & id_ready;
  assign npc_hs   = npc_valid & npc_ready;
  assign mem_done = (rres_valid & rres_ready) | (wres_valid & wres_ready);

  // responses are always taken, only one request can be out
  assign rres_ready = 1'b1;
  assign wres_ready = 1'b1;

  assign is_load  = (opcode == exu_pkg::OP_LOAD);
  assign is_store = (opcode == exu_pkg::OP_STORE);
  assign is_sys   = (opcode == exu_pkg::OP_SYS);
  assign csr_op   = is_sys & (funct != '0);   // csrrw and friends
  assign ecall    = is_sys & (funct == '0) & (imm[11:0] == '0);  // mret has 0x302 here

  always_comb begin
    case (opcode)
      exu_pkg::OP_LUI, exu_pkg::OP_AUIPC, exu_pkg::OP_JAL, exu_pkg::OP_JALR,
      exu_pkg::OP_LOAD, exu_pkg::OP_CALRI, exu_pkg::OP_CALRR: id_gpr_wen = 1'b1;
      exu_pkg::OP_SYS: id_gpr_wen = csr_op;  // old csr value goes to rd
      default:         id_gpr_wen = 1'b0;
    endcase
  end

  // link values for jumps also come out of the alu
  assign id_gpr_wdata = csr_op ? csr : alu_val;

  // mcause port never changes
  assign csr_waddr2 = exu_pkg::CSR_MCAUSE;
  assign csr_wdata2 = exu_pkg::CAUSE_ECALL_M;

  // the fsm alone decides when a new instruction may enter
  assign id_ready = (state == exu_pkg::EX_IDLE);

  always_comb begin
    state_nxt = state;
    case (state)
      exu_pkg::EX_IDLE: begin
        if (id_hs) begin
          state_nxt = (is_load | is_store) ? exu_pkg::EX_WAIT_BOTH : exu_pkg::EX_WAIT_NPC;
        end
      end
      exu_pkg::EX_WAIT_NPC: begin
        if (npc_hs) begin
          state_nxt = exu_pkg::EX_IDLE;
        end
      end
      exu_pkg::EX_WAIT_MEM: begin
        if (mem_done) begin
          state_nxt = exu_pkg::EX_IDLE;
        end
      end
      exu_pkg::EX_WAIT_BOTH: begin
        if (npc_hs & mem_done) begin
          state_nxt = exu_pkg::EX_IDLE;
        end else if (npc_hs) begin
          state_nxt = exu_pkg::EX_WAIT_MEM;
        end else if (mem_done) begin
          state_nxt = exu_pkg::EX_WAIT_NPC;
        end
      end
      default: begin
        state_nxt = exu_pkg::EX_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      state      <= exu_pkg::EX_IDLE;
      npc_valid  <= 1'b0;
      rreq_valid <= 1'b0;
      wreq_valid <= 1'b0;
      gpr_wen    <= 1'b0;
      csr_wen1   <= 1'b0;
      csr_wen2   <= 1'b0;
    end else begin
      state <= state_nxt;
      // single-cycle pulses, loads write once the data is back
      gpr_wen  <= (id_hs & id_gpr_wen & ~is_load) | (rres_valid & rres_ready);
      csr_wen1 <= id_hs & (csr_op | ecall);
      csr_wen2 <= id_hs & ecall;

      if (id_hs) begin
        npc_valid <= 1'b1;
      end else if (npc_hs) begin
        npc_valid <= 1'b0;
      end

      if (id_hs & is_load) begin
        rreq_valid <= 1'b1;
      end else if (rreq_valid & rreq_ready) begin
        rreq_valid <= 1'b0;
      end

      if (id_hs & is_store) begin
        wreq_valid <= 1'b1;
      end else if (wreq_valid & wreq_ready) begin
        wreq_valid <= 1'b0;
      end
    end
  end

  // payload latched on acceptance
  always_ff @(posedge clk) begin
    if (id_hs) begin
      npc        <= id_npc;
      gpr_waddr  <= rd;                         // also serves as rd for the load
      gpr_wdata  <= id_gpr_wdata;
      csr_waddr1 <= csr_op ? imm[11:0] : exu_pkg::CSR_MEPC;
      csr_wdata1 <= csr_op ? alu_val : pc;      // ecall saves pc in mepc
      if (is_load) begin
        mem_raddr <= alu_val;
        mem_rfunc <= funct;
      end
      if (is_store) begin
        mem_waddr <= alu_val;
        mem_wfunc <= funct;
        mem_wdata <= src2;
      end
    end
    if (rres_valid & rres_ready) begin
      gpr_wdata <= mem_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== source/lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu #(
  parameter int MEM_WORDS   = 256,
  parameter int MEM_LATENCY = 2    // at least 1
) (
  input  wire                   clk,
  input  wire                   rstn,
  input  wire                   rreq_valid,
  output logic                  rreq_ready,
  input  wire exu_pkg::word_t   mem_raddr,
  input  wire exu_pkg::funct_t  mem_rfunc,
  output logic                  rres_valid,
  input  wire                   rres_ready,
  output exu_pkg::word_t        mem_rdata,
  input  wire                   wreq_valid,
  output logic                  wreq_ready,
  input  wire exu_pkg::word_t   mem_waddr,
  input  wire exu_pkg::funct_t  mem_wfunc,
  input  wire exu_pkg::word_t   mem_wdata,
  output logic                  wres_valid,
  input  wire                   wres_ready
);

  localparam int AW = $clog2(MEM_WORDS);
  localparam int CW = $clog2(MEM_LATENCY + 1);

  exu_pkg::word_t mem [MEM_WORDS];

  logic busy;
  logic is_wr;           // pending op is a store
  logic [CW-1:0] cnt;
  logic rreq_hs;
  logic wreq_hs;
  logic [AW+1:0] raddr_q;
  exu_pkg::funct_t rfunc_q;
  logic [1:0] lane;
  logic [3:0] wr_be;
  exu_pkg::word_t wr_data;
  exu_pkg::word_t rd_word;
  exu_pkg::word_t rd_shift;

  assign rreq_ready = ~busy;
  assign wreq_ready = ~busy;
  assign rreq_hs    = rreq_valid & rreq_ready;
  assign wreq_hs    = wreq_valid & wreq_ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      busy       <= 1'b0;
      is_wr      <= 1'b0;
      cnt        <= '0;
      rres_valid <= 1'b0;
      wres_valid <= 1'b0;
    end else begin
      if (rreq_hs | wreq_hs) begin
        busy  <= 1'b1;
        is_wr <= ~rreq_hs;  // reads first, exu never sends both
        cnt   <= CW'(MEM_LATENCY);
      end else if (busy && cnt != '0) begin
        cnt <= cnt - 1'b1;
        if (cnt == CW'(1)) begin
          rres_valid <= ~is_wr;
          wres_valid <= is_wr;
        end
      end
      // response held until taken
      if (rres_valid & rres_ready) begin
        rres_valid <= 1'b0;
        busy       <= 1'b0;
      end
      if (wres_valid & wres_ready) begin
        wres_valid <= 1'b0;
        busy       <= 1'b0;
      end
    end
  end

  // store lanes
  assign lane = mem_waddr[1:0];

  always_comb begin
    case (mem_wfunc)
      exu_pkg::MEM_B: begin
        wr_be   = 4'b0001 << lane;
        wr_data = {4{mem_wdata[7:0]}};
      end
      exu_pkg::MEM_H: begin
        wr_be   = 4'b0011 << {lane[1], 1'b0};
        wr_data = {2{mem_wdata[15:0]}};
      end
      default: begin
        wr_be   = 4'b1111;
        wr_data = mem_wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (wreq_hs) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_be[i]) begin
          mem[mem_waddr[AW+1:2]][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
    if (rreq_hs) begin
      raddr_q <= mem_raddr[AW+1:0];
      rfunc_q <= mem_rfunc;
    end
  end

  // load path, addressed lane moved down to bit 0
  assign rd_word  = mem[raddr_q[AW+1:2]];
  assign rd_shift = rd_word >> {raddr_q[1:0], 3'b000};

  always_comb begin
    case (rfunc_q)
      exu_pkg::MEM_B:  mem_rdata = {{24{rd_shift[7]}}, rd_shift[7:0]};
      exu_pkg::MEM_BU: mem_rdata = {24'b0, rd_shift[7:0]};
      exu_pkg::MEM_H:  mem_rdata = {{16{rd_shift[15]}}, rd_shift[15:0]};
      exu_pkg::MEM_HU: mem_rdata = {16'b0, rd_shift[15:0]};
      default:         mem_rdata = rd_word;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_top #(
  parameter int MEM_WORDS   = 256,
  parameter int MEM_LATENCY = 2
) (
  input  wire                     clk,
  input  wire                     rstn,
  input  wire                     id_valid,
  output wire                     id_ready,
  input  wire exu_pkg::word_t     pc,
  input  wire exu_pkg::opcode_t   opcode,
  input  wire exu_pkg::funct_t    funct,
  input  wire exu_pkg::reg_addr_t rd,
  input  wire exu_pkg::word_t     src1,
  input  wire exu_pkg::word_t     src2,
  input  wire exu_pkg::word_t     imm,
  input  wire exu_pkg::word_t     csr,
  input  wire exu_pkg::word_t     alu_a,
  input  wire exu_pkg::word_t     alu_b,
  input  wire exu_pkg::funct_t    alu_funct,
  input  wire                     alu_funcs,
  output wire                     npc_valid,
  input  wire                     npc_ready,
  output wire exu_pkg::word_t     npc,
  output wire                     gpr_wen,
  output wire exu_pkg::reg_addr_t gpr_waddr,
  output wire exu_pkg::word_t     gpr_wdata,
  output wire                     csr_wen1,
  output wire exu_pkg::csr_addr_t csr_waddr1,
  output wire exu_pkg::word_t     csr_wdata1,
  output wire                     csr_wen2,
  output wire exu_pkg::csr_addr_t csr_waddr2,
  output wire exu_pkg::word_t     csr_wdata2
);

  // memory channels, exu <-> lsu
  wire                  rreq_valid;
  wire                  rreq_ready;
  wire exu_pkg::word_t  mem_raddr;
  wire exu_pkg::funct_t mem_rfunc;
  wire                  rres_valid;
  wire                  rres_ready;
  wire exu_pkg::word_t  mem_rdata;
  wire                  wreq_valid;
  wire                  wreq_ready;
  wire exu_pkg::word_t  mem_waddr;
  wire exu_pkg::funct_t mem_wfunc;
  wire exu_pkg::word_t  mem_wdata;
  wire                  wres_valid;
  wire                  wres_ready;

  // all port names match the nets above
  exu u_exu (.*);

  lsu #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_lsu (.*);

endmodule

`default_nettype wire

// ==== verification/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// lcg for npc_ready and operands
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [31:0] ref_alu(input logic [31:0] a, input logic [31:0] b,
                                        input logic [2:0] f, input logic alt);
  logic signed [31:0] sa;
  sa = a;
  case (f)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return {31'b0, (sa < $signed(b))};
    3'd3: return {31'b0, (a < b)};
    3'd4: return a ^ b;
    3'd5: return alt ? 32'(sa >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// next pc straight from the rv32i rules, comparing the sources directly
function automatic logic [31:0] ref_npc(input logic [4:0] op, input logic [2:0] f,
                                        input logic [31:0] pcv, input logic [31:0] s1,
                                        input logic [31:0] s2, input logic [31:0] im,
                                        input logic [31:0] cv);
  logic taken;
  logic [31:0] t;
  case (f)
    3'd0: taken = (s1 == s2);
    3'd1: taken = (s1 != s2);
    3'd4: taken = ($signed(s1) < $signed(s2));
    3'd5: taken = ($signed(s1) >= $signed(s2));
    3'd6: taken = (s1 < s2);
    default: taken = (s1 >= s2);
  endcase
  if (op == exu_pkg::OP_JAL) t = pcv + im;
  else if (op == exu_pkg::OP_JALR) t = s1 + im;
  else if (op == exu_pkg::OP_BRANCH) t = taken ? pcv + im : pcv + 4;
  else if (op == exu_pkg::OP_SYS && f == 3'd0) t = cv;  // ecall / mret
  else t = pcv + 4;
  return {t[31:1], 1'b0};
endfunction

// byte shadow of the data memory
task automatic shadow_store(input logic [31:0] addr, input logic [2:0] f,
                            input logic [31:0] data);
  logic [9:0] a;
  a = addr[9:0];
  case (f)
    3'd0: shadow[a] = data[7:0];
    3'd1: begin
      shadow[{a[9:1], 1'b0}] = data[7:0];
      shadow[{a[9:1], 1'b1}] = data[15:8];
    end
    default: begin
      for (int i = 0; i < 4; i++) shadow[{a[9:2], 2'(i)}] = data[8*i +: 8];
    end
  endcase
endtask

function automatic logic [31:0] shadow_load(input logic [31:0] addr, input logic [2:0] f);
  logic [9:0] a;
  logic [15:0] h;
  a = addr[9:0];
  h = {shadow[{a[9:1], 1'b1}], shadow[{a[9:1], 1'b0}]};
  case (f)
    3'd0: return {{24{shadow[a][7]}}, shadow[a]};
    3'd4: return {24'b0, shadow[a]};
    3'd1: return {{16{h[15]}}, h};
    3'd5: return {16'b0, h};
    default: return {shadow[{a[9:2], 2'd3}], shadow[{a[9:2], 2'd2}],
                     shadow[{a[9:2], 2'd1}], shadow[{a[9:2], 2'd0}]};
  endcase
endfunction

`endif

// ==== verification/tb_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top;

  localparam int TIMEOUT = 100;  // cycles per wait

  logic clk;
  logic rstn;
  logic id_valid;
  logic id_ready;
  exu_pkg::word_t pc, src1, src2, imm, csr, alu_a, alu_b, npc;
  exu_pkg::opcode_t opcode;
  exu_pkg::funct_t funct, alu_funct;
  exu_pkg::reg_addr_t rd, gpr_waddr;
  logic alu_funcs;
  logic npc_valid, npc_ready;
  logic gpr_wen, csr_wen1, csr_wen2;
  exu_pkg::word_t gpr_wdata, csr_wdata1, csr_wdata2;
  exu_pkg::csr_addr_t csr_waddr1, csr_waddr2;

  logic [7:0] shadow [0:1023];
  logic [31:0] rand_state;
  logic [31:0] ready_state;
  string test_name;
  int errors, errors_at_start, tests;
  logic started, after_id, id_xfer;
  logic hung;  // set once a wait ran out
  int wen_cnt;
  exu_pkg::word_t cur_pc;

  // model values latched at each id transfer
  exu_pkg::word_t exp_npc, exp_wdata, exp_csr1_data;
  exu_pkg::reg_addr_t exp_rd;
  exu_pkg::csr_addr_t exp_csr1_addr;
  logic exp_wen, exp_load, exp_csr1, exp_csr2;

  `include "tb_ref_model.svh"

  exec_top dut0 (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] rnd();
    rand_state = lcg_next(rand_state);
    return rand_state;
  endfunction

  task automatic value_error(input string what, input logic [31:0] e, input logic [31:0] a);
    $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, e, a);
    errors++;
  endtask

  task automatic failure(input string what);
    $display("%s: %s", test_name, what);
    errors++;
  endtask

  task automatic timed_out(input string what);
    $display("timeout in %s: %s", test_name, what);
    errors++;
    hung = 1'b1;
  endtask

  // fetch side with random back-pressure
  always @(posedge clk) begin
    ready_state <= lcg_next(ready_state);
    npc_ready <= ready_state[20] | ready_state[23];
  end

  assign id_xfer = id_valid & id_ready;

  always @(posedge clk) begin
    exu_pkg::word_t ea;
    logic csr_op, ecall;
    if (rstn) begin
      after_id <= 1'b0;
    end else begin
      after_id <= id_xfer;
      if (id_xfer) begin
        wen_cnt <= 0;
      end else if (gpr_wen) begin
        wen_cnt <= wen_cnt + 1;
      end
    end
    if (!rstn && id_xfer) begin
      ea = src1 + imm;
      csr_op = (opcode == exu_pkg::OP_SYS) && (funct != 3'd0);
      ecall = (opcode == exu_pkg::OP_SYS) && (funct == 3'd0) && (imm[11:0] == 12'h000);
      exp_npc <= ref_npc(opcode, funct, pc, src1, src2, imm, csr);
      exp_rd <= rd;
      exp_load <= (opcode == exu_pkg::OP_LOAD);
      exp_wen <= (opcode inside {exu_pkg::OP_LUI, exu_pkg::OP_AUIPC, exu_pkg::OP_JAL,
                                 exu_pkg::OP_JALR, exu_pkg::OP_LOAD, exu_pkg::OP_CALRI,
                                 exu_pkg::OP_CALRR}) || csr_op;
      if (opcode == exu_pkg::OP_LOAD) exp_wdata <= shadow_load(ea, funct);
      else if (csr_op) exp_wdata <= csr;
      else exp_wdata <= ref_alu(alu_a, alu_b, alu_funct, alu_funcs);
      exp_csr1 <= csr_op || ecall;
      exp_csr2 <= ecall;
      exp_csr1_addr <= csr_op ? imm[11:0] : 12'h341;
      exp_csr1_data <= csr_op ? src1 : pc;
      if (opcode == exu_pkg::OP_STORE) shadow_store(ea, funct, src2);
    end
  end

  a_reset_idle: assert property (@(posedge clk) disable iff (rstn)
    !started |-> id_ready && !npc_valid && !gpr_wen && !csr_wen1 && !csr_wen2)
    else failure("outputs not idle before the first instruction");
  a_npc_next: assert property (@(posedge clk) disable iff (rstn) id_xfer |=> npc_valid)
    else failure("npc_valid did not rise after the id transfer");
  a_npc_val: assert property (@(posedge clk) disable iff (rstn)
    npc_valid && npc_ready |-> npc == exp_npc)
    else value_error("npc", exp_npc, $sampled(npc));
  a_npc_hold: assert property (@(posedge clk) disable iff (rstn)
    npc_valid && !npc_ready |=> npc_valid && npc == $past(npc))
    else failure("npc or npc_valid changed while stalled");
  a_id_block: assert property (@(posedge clk) disable iff (rstn) npc_valid |-> !id_ready)
    else failure("id_ready high while npc is pending");
  a_gpr_first: assert property (@(posedge clk) disable iff (rstn)
    after_id |-> gpr_wen == (exp_wen && !exp_load))
    else value_error("gpr_wen", exp_wen && !exp_load, $sampled(gpr_wen));
  a_gpr_late: assert property (@(posedge clk) disable iff (rstn)
    gpr_wen && !after_id |-> exp_load)
    else failure("late gpr_wen for an instruction that is not a load");
  a_gpr_addr: assert property (@(posedge clk) disable iff (rstn)
    gpr_wen |-> gpr_waddr == exp_rd)
    else value_error("gpr_waddr", exp_rd, $sampled(gpr_waddr));
  a_gpr_data: assert property (@(posedge clk) disable iff (rstn)
    gpr_wen |-> gpr_wdata == exp_wdata)
    else value_error("gpr_wdata", exp_wdata, $sampled(gpr_wdata));
  a_csr1_en: assert property (@(posedge clk) disable iff (rstn)
    after_id |-> csr_wen1 == exp_csr1)
    else value_error("csr_wen1", exp_csr1, $sampled(csr_wen1));
  a_csr2_en: assert property (@(posedge clk) disable iff (rstn)
    after_id |-> csr_wen2 == exp_csr2)
    else value_error("csr_wen2", exp_csr2, $sampled(csr_wen2));
  a_csr_idle: assert property (@(posedge clk) disable iff (rstn)
    !after_id |-> !csr_wen1 && !csr_wen2)
    else failure("csr write pulse outside the cycle after an id transfer");
  a_csr1_addr: assert property (@(posedge clk) disable iff (rstn)
    csr_wen1 |-> csr_waddr1 == exp_csr1_addr)
    else value_error("csr_waddr1", exp_csr1_addr, $sampled(csr_waddr1));
  a_csr1_data: assert property (@(posedge clk) disable iff (rstn)
    csr_wen1 |-> csr_wdata1 == exp_csr1_data)
    else value_error("csr_wdata1", exp_csr1_data, $sampled(csr_wdata1));
  a_csr2_val: assert property (@(posedge clk) disable iff (rstn)
    csr_wen2 |-> csr_waddr2 == 12'h342 && csr_wdata2 == 32'd11)
    else value_error("mcause write", 32'd11, $sampled(csr_wdata2));

  // decoder model that builds the alu operands and runs one instruction to the end
  task automatic exec_instr(input exu_pkg::opcode_t op, input exu_pkg::funct_t f,
                            input logic alt, input exu_pkg::reg_addr_t r,
                            input exu_pkg::word_t s1, input exu_pkg::word_t s2,
                            input exu_pkg::word_t im, input exu_pkg::word_t cv);
    exu_pkg::word_t a, b;
    exu_pkg::funct_t af;
    logic as;
    int i;
    if (hung) return;
    a = s1;
    b = s2;
    af = f;
    as = 1'b0;
    case (op)
      exu_pkg::OP_CALRR: as = alt && (f == exu_pkg::ALU_ADD || f == exu_pkg::ALU_SR);
      exu_pkg::OP_CALRI: begin
        b = im;
        as = alt && (f == exu_pkg::ALU_SR);
      end
      exu_pkg::OP_BRANCH: begin
        if (f == exu_pkg::BR_BEQ || f == exu_pkg::BR_BNE) begin
          af = exu_pkg::ALU_ADD;
          as = 1'b1;
        end else if (f == exu_pkg::BR_BLT || f == exu_pkg::BR_BGE) begin
          af = exu_pkg::ALU_SLT;
        end else begin
          af = exu_pkg::ALU_SLTU;
        end
      end
      exu_pkg::OP_JAL, exu_pkg::OP_JALR: begin
        a = cur_pc;  // link value
        b = 32'd4;
        af = exu_pkg::ALU_ADD;
      end
      exu_pkg::OP_LUI: begin
        a = 32'd0;
        b = im;
        af = exu_pkg::ALU_ADD;
      end
      exu_pkg::OP_AUIPC: begin
        a = cur_pc;
        b = im;
        af = exu_pkg::ALU_ADD;
      end
      exu_pkg::OP_SYS: begin
        b = 32'd0;
        af = exu_pkg::ALU_ADD;
      end
      default: begin
        b = im;
        af = exu_pkg::ALU_ADD;
      end
    endcase
    @(posedge clk);
    id_valid <= 1'b1;
    pc <= cur_pc;
    opcode <= op;
    funct <= f;
    rd <= r;
    src1 <= s1;
    src2 <= s2;
    imm <= im;
    csr <= cv;
    alu_a <= a;
    alu_b <= b;
    alu_funct <= af;
    alu_funcs <= as;
    for (i = 0; i < TIMEOUT; i++) begin
      @(posedge clk);
      if (id_ready) break;
    end
    id_valid <= 1'b0;
    if (i == TIMEOUT) begin
      timed_out("id transfer never happened");
      return;
    end
    for (i = 0; i < TIMEOUT; i++) begin
      @(posedge clk);
      if (id_ready) break;
    end
    if (i == TIMEOUT) begin
      timed_out("id_ready did not return");
      return;
    end
    @(posedge clk);
    assert (wen_cnt == (exp_wen ? 1 : 0))
      else value_error("gpr_wen pulses", exp_wen ? 1 : 0, wen_cnt);
    cur_pc = exp_npc;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    $display("test %s: %0d errors", test_name, errors - errors_at_start);
    tests++;
  endtask

  task automatic random_alu_op();
    logic [31:0] r;
    r = rnd();
    if (r[30]) exec_instr(exu_pkg::OP_CALRR, r[14:12], r[25], r[11:7], rnd(), rnd(), 0, 0);
    else exec_instr(exu_pkg::OP_CALRI, r[14:12], r[25], r[11:7], rnd(), 0,
                    {{20{r[31]}}, r[31:20]}, 0);
  endtask

  initial begin
    logic [31:0] r, base, im;
    exu_pkg::word_t pairs [3][2];
    clk = 1'b0;
    rstn = 1'b1;
    id_valid = 1'b0;
    npc_ready = 1'b0;
    {pc, src1, src2, imm, csr, alu_a, alu_b} = '0;
    {opcode, funct, alu_funct, rd, alu_funcs} = '0;
    rand_state = 32'd43;
    ready_state = 32'd43;
    errors = 0;
    tests = 0;
    started = 1'b0;
    hung = 1'b0;
    cur_pc = 32'h100;
    pairs = '{'{32'd7, 32'd7}, '{32'hffff_fffe, 32'd5}, '{32'd5, 32'hffff_fffe}};
    repeat (4) @(posedge clk);
    rstn <= 1'b0;

    begin_test("reset");
    repeat (5) @(posedge clk);
    started = 1'b1;
    end_test();

    begin_test("alu");
    repeat (24) random_alu_op();
    end_test();

    begin_test("branch");
    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) continue;
      for (int p = 0; p < 3; p++) begin
        r = rnd();
        exec_instr(exu_pkg::OP_BRANCH, 3'(f), 0, 0, pairs[p][0], pairs[p][1],
                   {{20{r[31]}}, r[31:21], 1'b0}, 0);
      end
    end
    r = rnd();
    exec_instr(exu_pkg::OP_JAL, 0, 0, 5'd1, 0, 0, {{12{r[31]}}, r[31:13], 1'b0}, 0);
    exec_instr(exu_pkg::OP_JALR, 0, 0, 5'd5, rnd(), 0, 32'd13, 0);  // odd target
    exec_instr(exu_pkg::OP_LUI, 0, 0, 5'd6, 0, 0, {rnd() & 32'hffff_f000}, 0);
    exec_instr(exu_pkg::OP_AUIPC, 0, 0, 5'd7, 0, 0, {rnd() & 32'hffff_f000}, 0);
    end_test();

    begin_test("memory");
    for (int n = 0; n < 4; n++) begin
      r = rnd();
      base = {22'b0, r[15:8], 2'b00};
      im = {28'b0, r[3:0]};
      exec_instr(exu_pkg::OP_STORE, exu_pkg::MEM_W, 0, 0, base - im, rnd(), im, 0);
      exec_instr(exu_pkg::OP_STORE, exu_pkg::MEM_H, 0, 0, base + {r[17], 1'b0}, rnd(), 0, 0);
      exec_instr(exu_pkg::OP_STORE, exu_pkg::MEM_B, 0, 0, base + r[19:18], rnd(), 0, 0);
      exec_instr(exu_pkg::OP_LOAD, exu_pkg::MEM_W, 0, 5'd8, base - im, 0, im, 0);
      for (int k = 0; k < 4; k++) begin
        exec_instr(exu_pkg::OP_LOAD, exu_pkg::MEM_B, 0, 5'd9, base + k, 0, 0, 0);
        exec_instr(exu_pkg::OP_LOAD, exu_pkg::MEM_BU, 0, 5'd10, base + k, 0, 0, 0);
      end
      for (int k = 0; k < 2; k++) begin
        exec_instr(exu_pkg::OP_LOAD, exu_pkg::MEM_H, 0, 5'd11, base + 2 * k, 0, 0, 0);
        exec_instr(exu_pkg::OP_LOAD, exu_pkg::MEM_HU, 0, 5'd12, base + 2 * k, 0, 0, 0);
      end
    end
    end_test();

    begin_test("system");
    exec_instr(exu_pkg::OP_SYS, 0, 0, 0, 0, 0, 32'h000, {rnd() & 32'hffff_fffc});  // ecall
    exec_instr(exu_pkg::OP_SYS, 0, 0, 0, 0, 0, 32'h302, {rnd() & 32'hffff_fffc});  // mret
    exec_instr(exu_pkg::OP_SYS, 3'd1, 0, 5'd13, rnd(), 0, 32'h305, rnd());         // csrrw
    exec_instr(exu_pkg::OP_SYS, 3'd1, 0, 5'd14, rnd(), 0, 32'h340, rnd());
    end_test();

    begin_test("backpressure");
    for (int n = 0; n < 30; n++) begin
      r = rnd();
      if (r[27:26] == 2'b00) exec_instr(exu_pkg::OP_JAL, 0, 0, 5'd1, 0, 0, 32'd8, 0);
      else random_alu_op();
    end
    end_test();

    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verification
source/exu_pkg.sv
source/alu.sv
source/branch_unit.sv
source/exu.sv
source/lsu.sv
source/exec_top.sv
verification/tb_exec_top.sv
